// File: src/tile_pkg.sv
/*
  Shared definitions for the memory side of the tile. This holds the
  address map, the data and field widths, and the router state encoding.
  Modules take it with a wildcard import in the body and use scoped
  names in their port lists.
*/
package tile_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Local device field, address bits 23:20
  typedef logic [3:0] dev_id_t;
  // Register offset, address bits 7:0
  typedef logic [7:0] reg_off_t;
  typedef logic [7:0] tile_id_t;

  // Everything at or above this is DRAM
  localparam addr_t DRAM_BASE = 32'h8000_0000;

  localparam dev_id_t CACHE_DEV = 4'd0;
  localparam dev_id_t CLINT_DEV = 4'd1;
  localparam dev_id_t CFG_DEV   = 4'd2;

  // Config block offsets
  localparam reg_off_t CFG_SCRATCH_OFF = 8'h00;
  localparam reg_off_t CFG_FREEZE_OFF  = 8'h04;
  localparam reg_off_t CFG_ID_OFF      = 8'h08;

  // CLINT offsets
  localparam reg_off_t CLINT_MTIME_OFF    = 8'h00;
  localparam reg_off_t CLINT_MTIMECMP_OFF = 8'h04;
  localparam reg_off_t CLINT_MSIP_OFF     = 8'h08;

  typedef enum logic [2:0]
  {
    IDLE,
    EXEC,
    MEM_CMD,
    MEM_WAIT,
    RESP
  } route_state_e;

endpackage

// File: src/cmd_router.sv
`timescale 1ns/1ps
/*
  Command router. Accepts one host command at a time, decodes its address
  and sends it to the config block, the CLINT, the loopback target or the
  external memory port. The reply is held in a response register until
  the host takes it.
*/
module cmd_router
  (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cmd_valid_i,
  input  logic               cmd_write_i,
  input  tile_pkg::addr_t    cmd_addr_i,
  input  tile_pkg::data_t    cmd_data_i,
  output logic               cmd_ready_o,
  output logic               resp_valid_o,
  output tile_pkg::data_t    resp_data_o,
  input  logic               resp_ready_i,
  output logic               cfg_sel_o,
  output logic               clint_sel_o,
  output logic               dev_write_o,
  output tile_pkg::reg_off_t dev_off_o,
  output tile_pkg::data_t    dev_wdata_o,
  input  tile_pkg::data_t    cfg_rdata_i,
  input  tile_pkg::data_t    clint_rdata_i,
  output logic               mem_cmd_valid_o,
  output logic               mem_cmd_write_o,
  output tile_pkg::addr_t    mem_cmd_addr_o,
  output tile_pkg::data_t    mem_cmd_data_o,
  input  logic               mem_cmd_ready_i,
  input  logic               mem_resp_valid_i,
  input  tile_pkg::data_t    mem_resp_data_i,
  output logic               mem_resp_ready_o
  );
  import tile_pkg::*;

  route_state_e state_q, state_d;
  logic         cmd_fire;
  dev_id_t      in_dev;
  logic         in_local, in_mem, in_cfg, in_clint;
  logic         is_cfg_q, is_clint_q;
  logic         cmd_write_q;
  addr_t        cmd_addr_q;
  data_t        cmd_data_q;
  data_t        exec_rdata;
  data_t        resp_data_q;

  assign cmd_ready_o = (state_q == IDLE);
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  // Address decode on the incoming command
  assign in_dev   = cmd_addr_i[23:20];
  assign in_local = (cmd_addr_i < DRAM_BASE);
  assign in_mem   = !in_local || (in_dev == CACHE_DEV);
  assign in_cfg   = in_local && (in_dev == CFG_DEV);
  assign in_clint = in_local && (in_dev == CLINT_DEV);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (cmd_fire)
          state_d = in_mem ? MEM_CMD : EXEC;
      EXEC:
        state_d = RESP;
      MEM_CMD:
        if (mem_cmd_ready_i)
          state_d = MEM_WAIT;
      MEM_WAIT:
        if (mem_resp_valid_i)
          state_d = RESP;
      RESP:
        if (resp_ready_i)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= IDLE;
      is_cfg_q   <= 1'b0;
      is_clint_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (cmd_fire)
      begin
        is_cfg_q   <= in_cfg;
        is_clint_q <= in_clint;
      end
    end
  end

  // Held command payload
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      cmd_write_q <= cmd_write_i;
      cmd_addr_q  <= cmd_addr_i;
      cmd_data_q  <= cmd_data_i;
    end
  end

  // Loopback and all writes answer zero
  always_comb
  begin
    if (cmd_write_q)
      exec_rdata = '0;
    else if (is_cfg_q)
      exec_rdata = cfg_rdata_i;
    else if (is_clint_q)
      exec_rdata = clint_rdata_i;
    else
      exec_rdata = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == EXEC)
      resp_data_q <= exec_rdata;
    else if ((state_q == MEM_WAIT) && mem_resp_valid_i)
      resp_data_q <= cmd_write_q ? '0 : mem_resp_data_i;
  end

  assign cfg_sel_o   = (state_q == EXEC) && is_cfg_q;
  assign clint_sel_o = (state_q == EXEC) && is_clint_q;
  assign dev_write_o = cmd_write_q;
  assign dev_off_o   = cmd_addr_q[7:0];
  assign dev_wdata_o = cmd_data_q;

  assign mem_cmd_valid_o  = (state_q == MEM_CMD);
  assign mem_cmd_write_o  = cmd_write_q;
  assign mem_cmd_addr_o   = cmd_addr_q;
  assign mem_cmd_data_o   = cmd_data_q;
  assign mem_resp_ready_o = (state_q == MEM_WAIT);

  assign resp_valid_o = (state_q == RESP);
  assign resp_data_o  = resp_data_q;

  // One device at a time
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(cfg_sel_o && clint_sel_o));

  // Host sees a stable reply while stalling
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o));

endmodule

// File: src/cfg_regs.sv
`timescale 1ns/1ps
/*
  Configuration register block. Holds a scratch word and the freeze bit
  that stops the machine timer, and reads back the tile id.
*/
module cfg_regs
  #(
  parameter bit RESET_FREEZE = 1'b1
  )
  (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sel_i,
  input  logic               write_i,
  input  tile_pkg::reg_off_t off_i,
  input  tile_pkg::data_t    wdata_i,
  input  tile_pkg::tile_id_t tile_id_i,
  output tile_pkg::data_t    rdata_o,
  output logic               freeze_o
  );
  import tile_pkg::*;

  data_t scratch_q;
  logic  freeze_q;
  logic  wr_en;

  assign wr_en = sel_i && write_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      scratch_q <= '0;
      freeze_q  <= RESET_FREEZE;
    end
    else if (wr_en)
    begin
      // Id offset is read only
      if (off_i == CFG_SCRATCH_OFF)
        scratch_q <= wdata_i;
      if (off_i == CFG_FREEZE_OFF)
        freeze_q <= wdata_i[0];
    end
  end

  always_comb
  begin
    case (off_i)
      CFG_SCRATCH_OFF: rdata_o = scratch_q;
      CFG_FREEZE_OFF:  rdata_o = data_t'(freeze_q);
      CFG_ID_OFF:      rdata_o = data_t'(tile_id_i);
      default:         rdata_o = '0;
    endcase
  end

  assign freeze_o = freeze_q;

endmodule

// File: src/clint_slice.sv
`timescale 1ns/1ps
/*
  Core-local interrupt slice. Holds the machine timer, its compare value
  and the software interrupt bit, and drives the timer and software
  interrupt lines. The timer stops counting while freeze is set.
*/
module clint_slice
  (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sel_i,
  input  logic               write_i,
  input  tile_pkg::reg_off_t off_i,
  input  tile_pkg::data_t    wdata_i,
  input  logic               freeze_i,
  output tile_pkg::data_t    rdata_o,
  output logic               timer_irq_o,
  output logic               software_irq_o
  );
  import tile_pkg::*;

  data_t mtime_q;
  data_t mtimecmp_q;
  logic  msip_q;
  logic  timer_irq_q;
  logic  wr_en;
  logic  mtime_wr;
  logic  mtime_inc;

  assign wr_en     = sel_i && write_i;
  assign mtime_wr  = wr_en && (off_i == CLINT_MTIME_OFF);
  // Software write wins over the tick
  assign mtime_inc = !freeze_i && !mtime_wr;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      mtime_q <= '0;
    else if (mtime_wr)
      mtime_q <= wdata_i;
    else if (mtime_inc)
      mtime_q <= mtime_q + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end
    else
    begin
      if (wr_en && (off_i == CLINT_MTIMECMP_OFF))
        mtimecmp_q <= wdata_i;
      if (wr_en && (off_i == CLINT_MSIP_OFF))
        msip_q <= wdata_i[0];
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb
  begin
    case (off_i)
      CLINT_MTIME_OFF:    rdata_o = mtime_q;
      CLINT_MTIMECMP_OFF: rdata_o = mtimecmp_q;
      CLINT_MSIP_OFF:     rdata_o = data_t'(msip_q);
      default:            rdata_o = '0;
    endcase
  end

  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

  // A written mtime lands exactly, no tick on top
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mtime_wr |=> (mtime_q == $past(wdata_i)));

endmodule

// File: src/io_tile.sv
`timescale 1ns/1ps
/*
  Top of the tile's memory side. Takes host commands, routes them to the
  local devices or the external memory port, and returns one response
  per command. The incoming reset is registered once here and fanned out.
*/
module io_tile
  #(
  parameter bit RESET_FREEZE = 1'b1
  )
  (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  tile_pkg::tile_id_t tile_id_i,
  input  logic               cmd_valid_i,
  input  logic               cmd_write_i,
  input  tile_pkg::addr_t    cmd_addr_i,
  input  tile_pkg::data_t    cmd_data_i,
  output logic               cmd_ready_o,
  output logic               resp_valid_o,
  output tile_pkg::data_t    resp_data_o,
  input  logic               resp_ready_i,
  output logic               mem_cmd_valid_o,
  output logic               mem_cmd_write_o,
  output tile_pkg::addr_t    mem_cmd_addr_o,
  output tile_pkg::data_t    mem_cmd_data_o,
  input  logic               mem_cmd_ready_i,
  input  logic               mem_resp_valid_i,
  input  tile_pkg::data_t    mem_resp_data_i,
  output logic               mem_resp_ready_o,
  output logic               timer_irq_o,
  output logic               software_irq_o
  );
  import tile_pkg::*;

  logic     rst_n_r;
  logic     cfg_sel, clint_sel;
  logic     dev_write;
  reg_off_t dev_off;
  data_t    dev_wdata;
  data_t    cfg_rdata, clint_rdata;
  logic     freeze;

  always_ff @(posedge clk_i)
  begin
    rst_n_r <= rst_n_i;
  end

  cmd_router u_router
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_r),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_write_i      (cmd_write_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_valid_o     (resp_valid_o),
    .resp_data_o      (resp_data_o),
    .resp_ready_i     (resp_ready_i),
    .cfg_sel_o        (cfg_sel),
    .clint_sel_o      (clint_sel),
    .dev_write_o      (dev_write),
    .dev_off_o        (dev_off),
    .dev_wdata_o      (dev_wdata),
    .cfg_rdata_i      (cfg_rdata),
    .clint_rdata_i    (clint_rdata),
    .mem_cmd_valid_o  (mem_cmd_valid_o),
    .mem_cmd_write_o  (mem_cmd_write_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_data_o   (mem_cmd_data_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_ready_o (mem_resp_ready_o)
  );

  cfg_regs #(
    .RESET_FREEZE (RESET_FREEZE)
  ) u_cfg
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_r),
    .sel_i     (cfg_sel),
    .write_i   (dev_write),
    .off_i     (dev_off),
    .wdata_i   (dev_wdata),
    .tile_id_i (tile_id_i),
    .rdata_o   (cfg_rdata),
    .freeze_o  (freeze)
  );

  clint_slice u_clint
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_r),
    .sel_i          (clint_sel),
    .write_i        (dev_write),
    .off_i          (dev_off),
    .wdata_i        (dev_wdata),
    .freeze_i       (freeze),
    .rdata_o        (clint_rdata),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
/*
  Free-running testbench clock. The period is set in ns by the parameter.
*/
module tb_clock_gen
  #(
  parameter int PERIOD = 40
  )
  (
  output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// File: verif/tb_io_tile.sv
`timescale 1ns/1ps
/*
  Testbench for the tile's memory side. Drives host commands on the
  falling edge, models the external memory with random stalls, and
  checks every response against a reference model of the registers.
*/
module tb_io_tile;
  import tile_pkg::*;

  localparam int    TIMEOUT    = 100;
  localparam addr_t CLINT_BASE = addr_t'(CLINT_DEV) << 20;
  localparam addr_t CFG_BASE   = addr_t'(CFG_DEV) << 20;
  localparam addr_t LOOP_BASE  = addr_t'(4'd5) << 20;

  logic     clk_i;
  logic     rst_n_i;
  tile_id_t tile_id_i;
  logic     cmd_valid_i, cmd_write_i, cmd_ready_o;
  addr_t    cmd_addr_i;
  data_t    cmd_data_i;
  logic     resp_valid_o, resp_ready_i;
  data_t    resp_data_o;
  logic     mem_cmd_valid_o, mem_cmd_write_o, mem_cmd_ready_i;
  addr_t    mem_cmd_addr_o;
  data_t    mem_cmd_data_o;
  logic     mem_resp_valid_i, mem_resp_ready_o;
  data_t    mem_resp_data_i;
  logic     timer_irq_o, software_irq_o;

  // Reference model state
  data_t mem_ref [16];
  data_t mem_store [16];
  data_t scratch_ref, mtime_ref, mtimecmp_ref;
  logic  freeze_ref, msip_ref;

  int    checks;
  int    errors;
  int    cmd_stall;
  int    resp_stall;
  addr_t mem_addr_exp;

  tb_clock_gen #(.PERIOD (40)) u_clk (.clk_o (clk_i));

  io_tile #(.RESET_FREEZE (1'b1)) uut
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tile_id_i        (tile_id_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_write_i      (cmd_write_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_valid_o     (resp_valid_o),
    .resp_data_o      (resp_data_o),
    .resp_ready_i     (resp_ready_i),
    .mem_cmd_valid_o  (mem_cmd_valid_o),
    .mem_cmd_write_o  (mem_cmd_write_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_data_o   (mem_cmd_data_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .timer_irq_o      (timer_irq_o),
    .software_irq_o   (software_irq_o)
  );

  // Expected read data from the register map and memory model
  function automatic data_t ref_read(addr_t addr);
    dev_id_t  dev;
    reg_off_t off;
    dev = addr[23:20];
    off = addr[7:0];
    if ((addr >= DRAM_BASE) || (dev == CACHE_DEV))
      return mem_ref[addr[5:2]];
    if (dev == CFG_DEV)
    begin
      if (off == CFG_SCRATCH_OFF)
        return scratch_ref;
      if (off == CFG_FREEZE_OFF)
        return data_t'(freeze_ref);
      if (off == CFG_ID_OFF)
        return data_t'(tile_id_i);
      return '0;
    end
    if (dev == CLINT_DEV)
    begin
      if (off == CLINT_MTIME_OFF)
        return mtime_ref;
      if (off == CLINT_MTIMECMP_OFF)
        return mtimecmp_ref;
      if (off == CLINT_MSIP_OFF)
        return data_t'(msip_ref);
      return '0;
    end
    return '0;
  endfunction

  function automatic void ref_write(addr_t addr, data_t data);
    dev_id_t  dev;
    reg_off_t off;
    dev = addr[23:20];
    off = addr[7:0];
    if ((addr >= DRAM_BASE) || (dev == CACHE_DEV))
      mem_ref[addr[5:2]] = data;
    else if ((dev == CFG_DEV) && (off == CFG_SCRATCH_OFF))
      scratch_ref = data;
    else if ((dev == CFG_DEV) && (off == CFG_FREEZE_OFF))
      freeze_ref = data[0];
    else if ((dev == CLINT_DEV) && (off == CLINT_MTIME_OFF))
      mtime_ref = data;
    else if ((dev == CLINT_DEV) && (off == CLINT_MTIMECMP_OFF))
      mtimecmp_ref = data;
    else if ((dev == CLINT_DEV) && (off == CLINT_MSIP_OFF))
      msip_ref = data[0];
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    errors++;
    $display("Timeout at %0t ns: %s", $time, what);
    finish_run();
  endtask

  // One command and its response; stall holds the response back
  task automatic issue(input logic wr, input addr_t addr, input data_t data, input int stall);
    data_t exp;
    int    t;
    exp = wr ? '0 : ref_read(addr);
    if (wr)
      ref_write(addr, data);
    cmd_stall    = $urandom_range(0, 4);
    resp_stall   = $urandom_range(0, 4);
    mem_addr_exp = addr;
    cmd_valid_i  = 1'b1;
    cmd_write_i  = wr;
    cmd_addr_i   = addr;
    cmd_data_i   = data;
    t = 0;
    while (!cmd_ready_o && (t < TIMEOUT))
    begin
      @(negedge clk_i);
      t++;
    end
    if (!cmd_ready_o)
      timeout_abort("the command was never accepted");
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    t = 0;
    while (!resp_valid_o && (t < TIMEOUT))
    begin
      @(negedge clk_i);
      t++;
    end
    if (!resp_valid_o)
      timeout_abort("no response came back for the command");
    check_data(resp_data_o, exp, "response data");
    repeat (stall)
    begin
      @(negedge clk_i);
      if (!resp_valid_o)
      begin
        errors++;
        $display("Response valid dropped while the host stalled, at %0t ns", $time);
      end
      check_data(resp_data_o, exp, "stalled response data");
    end
    resp_ready_i = 1'b1;
    @(negedge clk_i);
    resp_ready_i = 1'b0;
  endtask

  // External memory with random ready and response delays
  always
  begin : mem_responder
    int idx;
    int t;
    @(negedge clk_i);
    if (mem_cmd_valid_o)
    begin
      repeat (cmd_stall) @(negedge clk_i);
      check_addr(mem_cmd_addr_o, mem_addr_exp, "memory command address");
      idx = mem_cmd_addr_o[5:2];
      mem_cmd_ready_i = 1'b1;
      if (mem_cmd_write_o)
        mem_store[idx] = mem_cmd_data_o;
      @(negedge clk_i);
      mem_cmd_ready_i = 1'b0;
      repeat (resp_stall) @(negedge clk_i);
      mem_resp_valid_i = 1'b1;
      // Junk on write replies, the tile must return zero
      mem_resp_data_i = mem_cmd_write_o ? ~mem_cmd_data_o : mem_store[idx];
      // Reply stays up until the tile takes it
      t = 0;
      while (!mem_resp_ready_o && (t < TIMEOUT))
      begin
        @(negedge clk_i);
        t++;
      end
      if (!mem_resp_ready_o)
        timeout_abort("the tile never took the memory response");
      @(negedge clk_i);
      mem_resp_valid_i = 1'b0;
    end
  end

  initial
  begin
    addr_t a;
    data_t v;
    int    i;
    void'($urandom(41));
    rst_n_i          = 1'b0;
    tile_id_i        = tile_id_t'($urandom);
    cmd_valid_i      = 1'b0;
    cmd_write_i      = 1'b0;
    cmd_addr_i       = '0;
    cmd_data_i       = '0;
    resp_ready_i     = 1'b0;
    mem_cmd_ready_i  = 1'b0;
    mem_resp_valid_i = 1'b0;
    mem_resp_data_i  = '0;
    checks           = 0;
    errors           = 0;
    cmd_stall        = 0;
    resp_stall       = 0;
    mem_addr_exp     = '0;
    for (i = 0; i < 16; i++)
    begin
      mem_ref[i]   = 32'h5a00_0000 + i * 32'h0001_0003;
      mem_store[i] = mem_ref[i];
    end
    scratch_ref  = '0;
    freeze_ref   = 1'b1;
    mtime_ref    = '0;
    mtimecmp_ref = '1;
    msip_ref     = 1'b0;

    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    // Let the registered reset release
    repeat (2) @(negedge clk_i);
    check_irq(timer_irq_o, 1'b0, "timer irq after reset");
    check_irq(software_irq_o, 1'b0, "software irq after reset");

    // Config block
    issue(1'b1, CFG_BASE | CFG_SCRATCH_OFF, $urandom, 0);
    issue(1'b0, CFG_BASE | CFG_SCRATCH_OFF, '0, 0);
    issue(1'b0, CFG_BASE | CFG_ID_OFF, '0, 0);
    issue(1'b1, CFG_BASE | CFG_ID_OFF, $urandom, 0);
    issue(1'b0, CFG_BASE | CFG_ID_OFF, '0, 0);
    issue(1'b0, CFG_BASE | CFG_SCRATCH_OFF, '0, 0);
    issue(1'b0, CFG_BASE | CFG_FREEZE_OFF, '0, 0);

    // Loopback
    issue(1'b0, LOOP_BASE | 32'h10, '0, 0);
    issue(1'b1, LOOP_BASE, $urandom, 0);
    issue(1'b0, LOOP_BASE, '0, 0);
    issue(1'b0, addr_t'(4'hf) << 20, '0, 0);

    // Memory, DRAM and cache device
    for (i = 0; i < 24; i++)
    begin
      if ($urandom_range(0, 1))
        a = DRAM_BASE | ($urandom & 32'h7fff_fffc);
      else
        a = $urandom & 32'h000f_fffc;
      issue(1'($urandom_range(0, 1)), a, $urandom, 0);
    end

    // Timer with freeze held
    v = 32'h100 + ($urandom & 32'h0fff_ffff);
    issue(1'b1, CLINT_BASE | CLINT_MTIME_OFF, v, 0);
    issue(1'b0, CLINT_BASE | CLINT_MTIME_OFF, '0, 0);
    issue(1'b1, CLINT_BASE | CLINT_MTIMECMP_OFF, v, 0);
    check_irq(timer_irq_o, mtime_ref >= mtimecmp_ref, "timer irq, compare equal");
    issue(1'b1, CLINT_BASE | CLINT_MTIMECMP_OFF, v - $urandom_range(1, 255), 0);
    check_irq(timer_irq_o, mtime_ref >= mtimecmp_ref, "timer irq, compare below");
    issue(1'b1, CLINT_BASE | CLINT_MTIMECMP_OFF, v + 1 + $urandom_range(0, 255), 0);
    check_irq(timer_irq_o, mtime_ref >= mtimecmp_ref, "timer irq, compare above");
    issue(1'b0, CLINT_BASE | CLINT_MTIMECMP_OFF, '0, 0);

    // Software interrupt
    issue(1'b1, CLINT_BASE | CLINT_MSIP_OFF, 32'h1, 0);
    check_irq(software_irq_o, msip_ref, "software irq set");
    issue(1'b0, CLINT_BASE | CLINT_MSIP_OFF, '0, 0);
    issue(1'b1, CLINT_BASE | CLINT_MSIP_OFF, 32'h0, 0);
    check_irq(software_irq_o, msip_ref, "software irq clear");

    // Host back-pressure on mixed targets
    for (i = 0; i < 8; i++)
    begin
      case ($urandom_range(0, 3))
        0:       a = CFG_BASE | CFG_SCRATCH_OFF;
        1:       a = DRAM_BASE | ($urandom & 32'h7fff_fffc);
        2:       a = LOOP_BASE;
        default: a = CLINT_BASE | CLINT_MTIMECMP_OFF;
      endcase
      issue(1'b0, a, '0, $urandom_range(1, 8));
    end

    finish_run();
  end

endmodule

// File: io_tile.f
src/tile_pkg.sv
src/cmd_router.sv
src/cfg_regs.sv
src/clint_slice.sv
src/io_tile.sv
verif/tb_clock_gen.sv
verif/tb_io_tile.sv

// File: Bender.yml
package:
  name: io_tile

sources:
  - src/tile_pkg.sv
  - src/cmd_router.sv
  - src/cfg_regs.sv
  - src/clint_slice.sv
  - src/io_tile.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_io_tile.sv
